/* bench/retire_checker.sv */
`timescale 1ns/1ps

module retire_checker import mips_pkg::*; (
        input  logic        clk,
        input  logic        arst_n,
        input  logic        retire_valid,
        input  retire_t     retire,
        input  logic [31:0] exp_words [0:296],
        output logic        done,
        output int          tests_ok,
        output int          tests_bad
);

        int rec   = 0;  // next record to match
        int seen  = 0;  // retirements since reset
        int errs  = 0;  // mismatches in the current test
        int ok_n  = 0;
        int bad_n = 0;
        int base;

        assign base      = rec * 9;
        assign done      = (exp_words[base] == '1);
        assign tests_ok  = ok_n;
        assign tests_bad = bad_n;

        task automatic check_field(input string name, input logic [31:0] want,
                                   input logic [31:0] got);
                if (got !== want) begin
                        $display("[FAIL] retire.%s at retirement %0d: expected %h, got %h",
                                 name, seen, want, got);
                        errs++;
                end
        endtask

        // **************************************************
        // sample on the commit edge
        // **************************************************
        always @(posedge clk) begin
                if (!arst_n && retire_valid) begin
                        $display("retire_valid was high while reset was asserted");
                        errs++;
                end
                if (retire_valid && !done && seen == exp_words[base + 1]) begin
                        check_field("pc", exp_words[base + 2], retire.pc);
                        check_field("reg_we", exp_words[base + 3], 32'(retire.reg_we));
                        check_field("reg_addr", exp_words[base + 4], 32'(retire.reg_addr));
                        check_field("reg_data", exp_words[base + 5], retire.reg_data);
                        check_field("mem_we", exp_words[base + 6], 32'(retire.mem_we));
                        check_field("mem_addr", exp_words[base + 7], retire.mem_addr);
                        check_field("mem_data", exp_words[base + 8], retire.mem_data);
                        if (exp_words[base + 9] != exp_words[base]) begin   // last of its test
                                $display("test %0d finished with %0d mismatches",
                                         exp_words[base], errs);
                                if (errs == 0) begin
                                        ok_n++;
                                end else begin
                                        bad_n++;
                                end
                                errs = 0;
                        end
                        rec++;
                end
                if (retire_valid) begin
                        seen++;
                end
        end

endmodule

/* bench/tb_mips.sv */
`timescale 1ns/1ps

module tb_mips import mips_pkg::*; ();

        localparam int timeout_cycles = 2000;

        logic        clk;
        logic        arst_n;
        logic        retire_valid;
        retire_t     retire;
        logic [31:0] exp_words [0:296];     // up to 33 records of 9 words
        logic        done;
        int          tests_ok;
        int          tests_bad;

        mips_core mips_core_i (.*);

        retire_checker retire_checker_i (.*);

        initial begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        // **************************************************
        // reset, data file, wait for the last record
        // **************************************************
        initial begin
                arst_n = 1'b0;
                for (int i = 0; i < 297; i++) begin
                        exp_words[i] = '1;      // all ones marks the end
                end
                $readmemh("bench/trace_input.txt", exp_words);
                repeat (16) @(posedge clk);
                #1 arst_n = 1'b1;
                for (int n = 0; n < timeout_cycles && !done; n++) begin
                        @(negedge clk);
                end
                if (!done) begin
                        $display("timeout: the trace never reached every expected record");
                end
                $display("tests passed %0d, failed %0d", tests_ok, tests_bad);
                if (done && tests_bad == 0) begin
                        $display("Everything OK");
                end else begin
                        $display("Something failed");
                end
                $finish;
        end

endmodule

/* bench/trace_input.txt */
// test  index  pc  reg_we  reg_addr  reg_data  mem_we  mem_addr  mem_data
// index counts retirements from zero after reset, every value in hex
1 0 00000000 0 00 00000000 0 00000000 00000000
2 1 00000004 1 01 00000000 0 00000000 00000000
2 1f 0000007c 1 1f 00000000 0 00000000 00000000
3 2d 000000a0 1 04 00000002 0 00000000 00000000
3 58 000000ac 1 07 00000028 0 00000000 00000000
4 5c 000000bc 1 11 ffffffff 0 00000000 00000000
4 60 000000cc 1 14 bfffffff 0 00000000 00000000
4 f3 000000c0 1 08 00000001 0 00000000 00000000
5 ff 000000dc 0 00 00000000 1 00000320 00ff00ff
5 100 000000e0 1 16 00ff00ff 0 00000000 00000000
5 108 000000e8 1 04 00000008 0 00000000 00000000
6 144 00000100 1 1f 00000104 0 00000000 00000000
6 146 00000104 0 00 00000000 0 00000000 00000000
6 147 00000000 0 00 00000000 0 00000000 00000000
6 28b 00000100 1 1f 00000104 0 00000000 00000000

/* files.f */
hw/mips_pkg.sv
hw/inst_rom.sv
hw/control_unit.sv
hw/pc_unit.sv
hw/reg_file.sv
hw/alu.sv
hw/data_ram.sv
hw/mips_core.sv
bench/retire_checker.sv
bench/tb_mips.sv

/* hw/alu.sv */
`timescale 1ns/1ps

module alu import mips_pkg::*; (
        input  alu_op_e     op,
        input  logic [31:0] a,
        input  logic [31:0] b,
        input  logic [4:0]  shamt,
        output logic [31:0] result,
        output logic        zero
);

        always_comb begin
                case (op)
                        alu_add: result = a + b;
                        alu_sub: result = a - b;
                        alu_and: result = a & b;
                        alu_or:  result = a | b;
                        alu_xor: result = a ^ b;
                        alu_nor: result = ~(a | b);
                        alu_slt: result = {31'd0, $signed(a) < $signed(b)};
                        alu_srl: result = b >> shamt;           // logical, rt operand
                        alu_lui: result = {b[15:0], 16'h0000};
                        default: result = '0;
                endcase
        end

        assign zero = (result == 32'd0);

endmodule

/* hw/control_unit.sv */
`timescale 1ns/1ps

module control_unit import mips_pkg::*; (
        input  logic [31:0] instr,
        input  logic        zero,
        output ctrl_t       ctrl,
        output pc_sel_e     pc_sel
);

        opcode_e op;
        funct_e  fn;

        assign op = opcode_e'(instr[31:26]);
        assign fn = funct_e'(instr[5:0]);

        always_comb begin
                ctrl        = '0;
                ctrl.alu_op = alu_add;
                pc_sel      = pc_seq;

                case (op)
                        op_rtype: begin
                                ctrl.reg_we     = 1'b1;
                                ctrl.reg_dst_rd = 1'b1;
                                case (fn)
                                        fn_add: ctrl.alu_op = alu_add;
                                        fn_sub: ctrl.alu_op = alu_sub;
                                        fn_and: ctrl.alu_op = alu_and;
                                        fn_or:  ctrl.alu_op = alu_or;
                                        fn_xor: ctrl.alu_op = alu_xor;
                                        fn_nor: ctrl.alu_op = alu_nor;
                                        fn_slt: ctrl.alu_op = alu_slt;
                                        fn_srl: ctrl.alu_op = alu_srl;
                                        fn_jr: begin
                                                ctrl.reg_we = 1'b0;
                                                pc_sel      = pc_reg;
                                        end
                                        default: ctrl.reg_we = 1'b0;   // sll and others
                                endcase
                        end
                        op_addi: begin
                                ctrl.alu_src_imm = 1'b1;   // no overflow trap
                                ctrl.reg_we      = 1'b1;
                        end
                        op_lui: begin
                                ctrl.alu_op       = alu_lui;
                                ctrl.alu_src_imm  = 1'b1;
                                ctrl.imm_zero_ext = 1'b1;
                                ctrl.reg_we       = 1'b1;
                        end
                        op_lw: begin
                                ctrl.alu_src_imm = 1'b1;
                                ctrl.reg_we      = 1'b1;
                                ctrl.mem_to_reg  = 1'b1;
                        end
                        op_sw: begin
                                ctrl.alu_src_imm = 1'b1;
                                ctrl.mem_we      = 1'b1;
                        end
                        op_beq: begin
                                ctrl.alu_op = alu_sub;
                                if (zero) pc_sel = pc_branch;
                        end
                        op_bne: begin
                                ctrl.alu_op = alu_sub;
                                if (!zero) pc_sel = pc_branch;
                        end
                        op_j: pc_sel = pc_jump;
                        op_jal: begin
                                ctrl.reg_we  = 1'b1;
                                ctrl.link_ra = 1'b1;
                                pc_sel       = pc_jump;
                        end
                        default: ;      // unknown opcode, nothing written
                endcase
        end

endmodule

/* hw/data_ram.sv */
`timescale 1ns/1ps

module data_ram import mips_pkg::*; (
        input  logic        clk,
        input  logic        we,
        input  logic [7:0]  word_addr,
        input  logic [31:0] wdata,
        output logic [31:0] rdata
);

        logic [31:0] mem [ram_depth];

        always_ff @(posedge clk) begin
                if (we) begin
                        mem[word_addr] <= wdata;
                end
        end

        assign rdata = mem[word_addr];  // same-cycle read for lw

endmodule

/* hw/inst_rom.sv */
`timescale 1ns/1ps

module inst_rom import mips_pkg::*; (
        input  logic [6:0]  word_addr,
        output logic [31:0] instr
);

        logic [31:0] rom [rom_depth];

        initial begin
                for (int i = 0; i < rom_depth; i++) begin
                        rom[i] = '0;
                end
                // clear r0..r31 with xor
                rom[0]  = 32'h00000026;
                rom[1]  = 32'h00210826;
                rom[2]  = 32'h00421026;
                rom[3]  = 32'h00631826;
                rom[4]  = 32'h00842026;
                rom[5]  = 32'h00a52826;
                rom[6]  = 32'h00c63026;
                rom[7]  = 32'h00e73826;
                rom[8]  = 32'h01084026;
                rom[9]  = 32'h01294826;
                rom[10] = 32'h014a5026;
                rom[11] = 32'h016b5826;
                rom[12] = 32'h018c6026;
                rom[13] = 32'h01ad6826;
                rom[14] = 32'h01ce7026;
                rom[15] = 32'h01ef7826;
                rom[16] = 32'h02108026;
                rom[17] = 32'h02318826;
                rom[18] = 32'h02529026;
                rom[19] = 32'h02739826;
                rom[20] = 32'h0294a026;
                rom[21] = 32'h02b5a826;
                rom[22] = 32'h02d6b026;
                rom[23] = 32'h02f7b826;
                rom[24] = 32'h0318c026;
                rom[25] = 32'h0339c826;
                rom[26] = 32'h035ad026;
                rom[27] = 32'h037bd826;
                rom[28] = 32'h039ce026;
                rom[29] = 32'h03bde826;
                rom[30] = 32'h03def026;
                rom[31] = 32'h03fff826;
                // addi setup, then add loop
                rom[32] = 32'h2108000a;
                rom[33] = 32'h21290001;
                rom[34] = 32'h214a0002;
                rom[35] = 32'h216b0003;
                rom[36] = 32'h218c0004;
                rom[37] = 32'h21ad000a;
                rom[38] = 32'h21ce000a;
                rom[39] = 32'h21ef000a;
                rom[40] = 32'h00892020;
                rom[41] = 32'h00aa2820;
                rom[42] = 32'h00cb3020;
                rom[43] = 32'h00ec3820;
                rom[44] = 32'h1488fffb;
                // shift loop
                rom[45] = 32'h22100001;
                rom[46] = 32'h3c088000;
                rom[47] = 32'h00008827;
                rom[48] = 32'h00084042;
                rom[49] = 32'h02119024;
                rom[50] = 32'h01119825;
                rom[51] = 32'h0111a026;
                rom[52] = 32'h1408fffb;
                // store / load round trip
                rom[53] = 32'h3c1500ff;
                rom[54] = 32'h22b500ff;
                rom[55] = 32'hac150320;
                rom[56] = 32'h8c160320;
                rom[57] = 32'h12b60000;
                rom[58] = 32'h00892022;
                rom[59] = 32'h00aa2822;
                rom[60] = 32'h00cb3022;
                rom[61] = 32'h00ec3822;
                rom[62] = 32'h00c0402a;
                rom[63] = 32'h1008fffa;
                // jal, j, jr
                rom[64] = 32'h0c000042;
                rom[65] = 32'h08000000;
                rom[66] = 32'h03e00008;
        end

        assign instr = rom[word_addr];  // zero past word 66

endmodule

/* hw/mips_core.sv */
`timescale 1ns/1ps

module mips_core import mips_pkg::*; (
        input  logic    clk,
        input  logic    arst_n,
        output logic    retire_valid,
        output retire_t retire
);

        logic [31:0] pc;
        logic [31:0] pc_plus4;
        logic [31:0] instr;
        ctrl_t       ctrl;
        pc_sel_e     pc_sel;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        logic [4:0]  waddr;
        logic [15:0] imm;
        logic [31:0] imm_ext;
        logic [31:0] rs_data;
        logic [31:0] rt_data;
        logic [31:0] alu_b;
        logic [31:0] alu_result;
        logic [31:0] ram_rdata;
        logic [31:0] wb_data;
        logic        zero;
        logic        running;
        logic        wb_seen;

        // **************************************************
        // field slicing and muxes
        // **************************************************
        assign rs      = instr[25:21];
        assign rt      = instr[20:16];
        assign rd      = instr[15:11];
        assign shamt   = instr[10:6];
        assign imm     = instr[15:0];
        assign imm_ext = ctrl.imm_zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};
        assign alu_b   = ctrl.alu_src_imm ? imm_ext : rt_data;

        assign waddr   = ctrl.link_ra ? 5'd31 : (ctrl.reg_dst_rd ? rd : rt);
        assign wb_data = ctrl.link_ra    ? pc_plus4  :
                         ctrl.mem_to_reg ? ram_rdata : alu_result;

        // **************************************************
        // datapath
        // **************************************************
        pc_unit pc_unit_i (
                .clk        (clk),
                .arst_n     (arst_n),
                .pc_sel     (pc_sel),
                .imm        (imm),
                .jump_index (instr[25:0]),
                .rs_data    (rs_data),
                .pc         (pc),
                .pc_plus4   (pc_plus4)
        );

        inst_rom inst_rom_i (
                .word_addr (pc[8:2]),
                .instr     (instr)
        );

        control_unit control_unit_i (
                .instr  (instr),
                .zero   (zero),
                .ctrl   (ctrl),
                .pc_sel (pc_sel)
        );

        reg_file reg_file_i (
                .clk     (clk),
                .arst_n  (arst_n),
                .rs_addr (rs),
                .rt_addr (rt),
                .we      (ctrl.reg_we),
                .waddr   (waddr),
                .wdata   (wb_data),
                .rs_data (rs_data),
                .rt_data (rt_data)
        );

        alu alu_i (
                .op     (ctrl.alu_op),
                .a      (rs_data),
                .b      (alu_b),
                .shamt  (shamt),
                .result (alu_result),
                .zero   (zero)
        );

        data_ram data_ram_i (
                .clk       (clk),
                .we        (ctrl.mem_we & running),
                .word_addr (alu_result[9:2]),
                .wdata     (rt_data),
                .rdata     (ram_rdata)
        );

        // **************************************************
        // retire trace
        // **************************************************
        // falling edge after release, so word 0 is shown before it commits
        always_ff @(negedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        running <= 1'b0;
                end else begin
                        running <= 1'b1;
                end
        end

        assign retire_valid = running;
        assign wb_seen      = ctrl.reg_we && (waddr != 5'd0);

        always_comb begin
                retire          = '0;
                retire.pc       = pc;
                retire.instr    = instr;
                retire.reg_we   = wb_seen;
                retire.mem_we   = ctrl.mem_we;
                if (wb_seen) begin
                        retire.reg_addr = waddr;
                        retire.reg_data = wb_data;
                end
                if (ctrl.mem_we) begin
                        retire.mem_addr = alu_result;   // byte address
                        retire.mem_data = rt_data;
                end
        end

endmodule

/* hw/mips_pkg.sv */
package mips_pkg;

        // **************************************************
        // sizes
        // **************************************************
        localparam int          rom_depth = 128;
        localparam int          ram_depth = 256;
        localparam logic [31:0] reset_pc  = 32'h0000_0000;

        // **************************************************
        // instruction encodings
        // **************************************************
        typedef enum logic [5:0] {
                op_rtype = 6'h00,
                op_j     = 6'h02,
                op_jal   = 6'h03,
                op_beq   = 6'h04,
                op_bne   = 6'h05,
                op_addi  = 6'h08,
                op_lui   = 6'h0f,
                op_lw    = 6'h23,
                op_sw    = 6'h2b
        } opcode_e;

        typedef enum logic [5:0] {
                fn_srl = 6'h02,
                fn_jr  = 6'h08,
                fn_add = 6'h20,
                fn_sub = 6'h22,
                fn_and = 6'h24,
                fn_or  = 6'h25,
                fn_xor = 6'h26,
                fn_nor = 6'h27,
                fn_slt = 6'h2a
        } funct_e;

        typedef enum logic [3:0] {
                alu_add,
                alu_sub,
                alu_and,
                alu_or,
                alu_xor,
                alu_nor,
                alu_slt,
                alu_srl,
                alu_lui
        } alu_op_e;

        typedef enum logic [1:0] {
                pc_seq,
                pc_branch,
                pc_jump,
                pc_reg
        } pc_sel_e;

        // **************************************************
        // bundles
        // **************************************************
        typedef struct packed {
                alu_op_e alu_op;
                logic    alu_src_imm;   // b operand is the immediate
                logic    imm_zero_ext;
                logic    reg_we;
                logic    reg_dst_rd;    // rd, else rt
                logic    link_ra;       // jal writes pc+4 to r31
                logic    mem_we;
                logic    mem_to_reg;
        } ctrl_t;

        typedef struct packed {
                logic [31:0] pc;
                logic [31:0] instr;
                logic        reg_we;
                logic [4:0]  reg_addr;
                logic [31:0] reg_data;
                logic        mem_we;
                logic [31:0] mem_addr;
                logic [31:0] mem_data;
        } retire_t;

endpackage

/* hw/pc_unit.sv */
`timescale 1ns/1ps

module pc_unit import mips_pkg::*; (
        input  logic        clk,
        input  logic        arst_n,
        input  pc_sel_e     pc_sel,
        input  logic [15:0] imm,
        input  logic [25:0] jump_index,
        input  logic [31:0] rs_data,
        output logic [31:0] pc,
        output logic [31:0] pc_plus4
);

        logic [31:0] branch_target;
        logic [31:0] jump_target;
        logic [31:0] pc_next;

        assign pc_plus4      = pc + 32'd4;
        assign branch_target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
        assign jump_target   = {pc_plus4[31:28], jump_index, 2'b00};

        always_comb begin
                case (pc_sel)
                        pc_branch: pc_next = branch_target;
                        pc_jump:   pc_next = jump_target;
                        pc_reg:    pc_next = rs_data;  // jr
                        default:   pc_next = pc_plus4;
                endcase
        end

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        pc <= reset_pc;
                end else begin
                        pc <= pc_next;
                end
        end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
        input  logic        clk,
        input  logic        arst_n,
        input  logic [4:0]  rs_addr,
        input  logic [4:0]  rt_addr,
        input  logic        we,
        input  logic [4:0]  waddr,
        input  logic [31:0] wdata,
        output logic [31:0] rs_data,
        output logic [31:0] rt_data
);

        logic [31:0] regs [32];

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        for (int i = 0; i < 32; i++) begin
                                regs[i] <= '0;
                        end
                end else if (we && waddr != 5'd0) begin   // r0 stays zero
                        regs[waddr] <= wdata;
                end
        end

        assign rs_data = regs[rs_addr];
        assign rt_data = regs[rt_addr];

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --top-module tb_mips -f files.f -o tb_mips_sim
./obj_dir/tb_mips_sim | tee sim.log

if grep -q "Something failed" sim.log; then
        exit 1
fi
